// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// --------------------
// Datapath sizing
// --------------------

// Width of one integer register and of the program counter
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Bits needed to name one of REG_COUNT registers
`define REG_ADDR_W 5

`endif

// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

  typedef logic [31:0] instr_t;   // One uncompressed instruction word
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // --------------------
  // Major opcode, instruction bits 6 to 2
  // --------------------
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;

  // --------------------
  // funct3 values
  // --------------------
  localparam funct3_t F3_ADD_SUB = 3'b000;   // Also ADDI
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;   // funct7 picks logical or arithmetic
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;

  localparam funct3_t F3_SB = 3'b000;
  localparam funct3_t F3_SH = 3'b001;
  localparam funct3_t F3_SW = 3'b010;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct7_t F7_ALT = 7'b0100000;   // Marks SUB, SRA and SRAI

endpackage

`default_nettype wire

// ==== core_id_pkg.sv ====
`default_nettype none

`include "core_config.svh"

package core_id_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // --------------------
  // Operation codes handed to execute
  // --------------------
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,   // Zero so an unknown instruction lands here
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Same encoding as the load funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE   = 3'd0,
    BR_EQ     = 3'd1,
    BR_NE     = 3'd2,
    BR_LT     = 3'd3,
    BR_GE     = 3'd4,
    BR_LTU    = 3'd5,
    BR_GEU    = 3'd6,
    BR_ALWAYS = 3'd7   // JAL and JALR
  } br_op_e;

endpackage

`default_nettype wire

// ==== id_ctrl_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_ctrl_decode (
  input  riscv_isa_pkg::instr_t   instr,
  output core_id_pkg::alu_op_e    alu_op,
  output logic                    reg_write,
  output logic                    mem_read,
  output logic                    mem_write,
  output core_id_pkg::mem_op_e    mem_op,
  output core_id_pkg::br_op_e     br_op,
  output core_id_pkg::reg_addr_t  rd
);

  riscv_isa_pkg::opcode_e  opcode;
  riscv_isa_pkg::funct3_t  funct3;
  logic                    alt_op;      // funct7 selects SUB or SRA
  logic                    writes_rd;   // Class produces a register result

  // ALU operation shared by register-register and register-immediate forms
  function automatic core_id_pkg::alu_op_e alu_sel(riscv_isa_pkg::funct3_t f3,
                                                   logic alt, logic allow_sub);
    core_id_pkg::alu_op_e op;
    op = core_id_pkg::ALU_ADD;
    case (f3)
      riscv_isa_pkg::F3_ADD_SUB: op = (alt && allow_sub) ? core_id_pkg::ALU_SUB
                                                          : core_id_pkg::ALU_ADD;
      riscv_isa_pkg::F3_SLL:     op = core_id_pkg::ALU_SLL;
      riscv_isa_pkg::F3_SLT:     op = core_id_pkg::ALU_SLT;
      riscv_isa_pkg::F3_SLTU:    op = core_id_pkg::ALU_SLTU;
      riscv_isa_pkg::F3_XOR:     op = core_id_pkg::ALU_XOR;
      riscv_isa_pkg::F3_SRL_SRA: op = alt ? core_id_pkg::ALU_SRA : core_id_pkg::ALU_SRL;
      riscv_isa_pkg::F3_OR:      op = core_id_pkg::ALU_OR;
      riscv_isa_pkg::F3_AND:     op = core_id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = riscv_isa_pkg::opcode_e'(instr[6:2]);
  assign funct3    = instr[14:12];
  assign alt_op    = (instr[31:25] == riscv_isa_pkg::F7_ALT);
  assign rd        = instr[11:7];
  assign reg_write = writes_rd && (rd != '0);   // Writes to x0 are dropped here

  // --------------------
  // Opcode classification
  // --------------------
  always_comb begin
    alu_op    = core_id_pkg::ALU_ADD;   // Address and link arithmetic is an add
    writes_rd = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    mem_op    = core_id_pkg::MEM_B;
    br_op     = core_id_pkg::BR_NONE;
    case (opcode)
      riscv_isa_pkg::OPC_OP: begin
        alu_op    = alu_sel(funct3, alt_op, 1'b1);
        writes_rd = 1'b1;
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        alu_op    = alu_sel(funct3, alt_op, 1'b0);   // ADDI has no subtract form
        writes_rd = 1'b1;
      end
      riscv_isa_pkg::OPC_LOAD: begin
        writes_rd = 1'b1;
        mem_read  = 1'b1;
        case (funct3)
          riscv_isa_pkg::F3_LB:  mem_op = core_id_pkg::MEM_B;
          riscv_isa_pkg::F3_LH:  mem_op = core_id_pkg::MEM_H;
          riscv_isa_pkg::F3_LBU: mem_op = core_id_pkg::MEM_BU;
          riscv_isa_pkg::F3_LHU: mem_op = core_id_pkg::MEM_HU;
          default:               mem_op = core_id_pkg::MEM_W;
        endcase
      end
      riscv_isa_pkg::OPC_STORE: begin
        mem_write = 1'b1;
        case (funct3)
          riscv_isa_pkg::F3_SB: mem_op = core_id_pkg::MEM_B;
          riscv_isa_pkg::F3_SH: mem_op = core_id_pkg::MEM_H;
          default:              mem_op = core_id_pkg::MEM_W;
        endcase
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        case (funct3)
          riscv_isa_pkg::F3_BEQ:  br_op = core_id_pkg::BR_EQ;
          riscv_isa_pkg::F3_BNE:  br_op = core_id_pkg::BR_NE;
          riscv_isa_pkg::F3_BLT:  br_op = core_id_pkg::BR_LT;
          riscv_isa_pkg::F3_BGE:  br_op = core_id_pkg::BR_GE;
          riscv_isa_pkg::F3_BLTU: br_op = core_id_pkg::BR_LTU;
          riscv_isa_pkg::F3_BGEU: br_op = core_id_pkg::BR_GEU;
          default:                br_op = core_id_pkg::BR_NONE;
        endcase
      end
      riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR: begin
        writes_rd = 1'b1;   // Link address goes to rd
        br_op     = core_id_pkg::BR_ALWAYS;
      end
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC: begin
        writes_rd = 1'b1;
      end
      default: begin
        writes_rd = 1'b0;   // Unknown opcode leaves every control inactive
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== id_operand_read.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module id_operand_read (
  input  logic                    clk,
  input  logic                    rst_n,
  input  riscv_isa_pkg::instr_t   instr,
  input  logic                    wb_reg_write,
  input  core_id_pkg::reg_addr_t  wb_rd,
  input  core_id_pkg::xlen_t      wb_data,
  output core_id_pkg::xlen_t      imm,
  output core_id_pkg::xlen_t      rs1_value,
  output core_id_pkg::xlen_t      rs2_value,
  output core_id_pkg::reg_addr_t  rs1,
  output core_id_pkg::reg_addr_t  rs2
);

  core_id_pkg::xlen_t regs [`REG_COUNT];

  // Register 0 is hard zero, a write landing this cycle wins over the array
  function automatic core_id_pkg::xlen_t read_port(core_id_pkg::reg_addr_t addr);
    core_id_pkg::xlen_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wb_reg_write && (wb_rd == addr)) begin
      value = wb_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // --------------------
  // Immediate extraction
  // --------------------
  always_comb begin
    case (riscv_isa_pkg::opcode_e'(instr[6:2]))
      riscv_isa_pkg::OPC_OP_IMM, riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_JALR:
        imm = core_id_pkg::xlen_t'($signed(instr[31:20]));   // I format
      riscv_isa_pkg::OPC_STORE:
        imm = core_id_pkg::xlen_t'($signed({instr[31:25], instr[11:7]}));
      riscv_isa_pkg::OPC_BRANCH:
        imm = core_id_pkg::xlen_t'($signed({instr[31], instr[7], instr[30:25],
                                            instr[11:8], 1'b0}));
      riscv_isa_pkg::OPC_JAL:
        imm = core_id_pkg::xlen_t'($signed({instr[31], instr[19:12], instr[20],
                                            instr[30:21], 1'b0}));
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC:
        imm = core_id_pkg::xlen_t'($signed({instr[31:12], 12'b0}));   // U format
      default:
        imm = '0;
    endcase
  end

  // --------------------
  // Register file
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_reg_write && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_value = read_port(rs1);
    rs2_value = read_port(rs2);
  end

endmodule

`default_nettype wire

// ==== id_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fd_valid,
  output logic                    fd_ready,
  input  logic                    ex_flush_en,
  input  logic                    de_ready,
  output logic                    de_valid,
  input  core_id_pkg::xlen_t      pc,
  input  core_id_pkg::alu_op_e    alu_op,
  input  logic                    reg_write,
  input  logic                    mem_read,
  input  logic                    mem_write,
  input  core_id_pkg::mem_op_e    mem_op,
  input  core_id_pkg::br_op_e     br_op,
  input  core_id_pkg::reg_addr_t  rd,
  input  core_id_pkg::reg_addr_t  rs1,
  input  core_id_pkg::reg_addr_t  rs2,
  input  core_id_pkg::xlen_t      imm,
  input  core_id_pkg::xlen_t      rs1_value,
  input  core_id_pkg::xlen_t      rs2_value,
  output core_id_pkg::xlen_t      de_pc,
  output core_id_pkg::alu_op_e    de_alu_op,
  output logic                    de_reg_write,
  output logic                    de_mem_read,
  output logic                    de_mem_write,
  output core_id_pkg::mem_op_e    de_mem_op,
  output core_id_pkg::br_op_e     de_br_op,
  output core_id_pkg::reg_addr_t  de_rd,
  output core_id_pkg::reg_addr_t  de_rs1,
  output core_id_pkg::reg_addr_t  de_rs2,
  output core_id_pkg::xlen_t      de_imm,
  output core_id_pkg::xlen_t      de_rs1_value,
  output core_id_pkg::xlen_t      de_rs2_value
);

  logic fd_fire;

  // A flush blocks intake for the whole cycle
  assign fd_ready = !ex_flush_en && (!de_valid || de_ready);
  assign fd_fire  = fd_valid && fd_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_valid <= 1'b0;
    end else if (ex_flush_en) begin
      de_valid <= 1'b0;   // Held instruction is dropped even if de_ready was high
    end else if (fd_ready) begin
      de_valid <= fd_valid;
    end
  end

  // Payload only moves on an accepted instruction
  always_ff @(posedge clk) begin
    if (fd_fire) begin
      de_pc        <= pc;
      de_alu_op    <= alu_op;
      de_reg_write <= reg_write;
      de_mem_read  <= mem_read;
      de_mem_write <= mem_write;
      de_mem_op    <= mem_op;
      de_br_op     <= br_op;
      de_rd        <= rd;
      de_rs1       <= rs1;
      de_rs2       <= rs2;
      de_imm       <= imm;
      de_rs1_value <= rs1_value;
      de_rs2_value <= rs2_value;
    end
  end

endmodule

`default_nettype wire

// ==== core_id.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_id (
  input  logic                    clk,
  input  logic                    rst_n,
  // --------------------
  // Fetch side
  // --------------------
  input  logic                    fd_valid,
  output logic                    fd_ready,
  input  riscv_isa_pkg::instr_t   fd_instr,
  input  core_id_pkg::xlen_t      fd_pc,
  input  logic                    ex_flush_en,
  // --------------------
  // Writeback port
  // --------------------
  input  logic                    wb_reg_write,
  input  core_id_pkg::reg_addr_t  wb_rd,
  input  core_id_pkg::xlen_t      wb_data,
  // --------------------
  // Execute side
  // --------------------
  output logic                    de_valid,
  input  logic                    de_ready,
  output core_id_pkg::xlen_t      de_pc,
  output core_id_pkg::alu_op_e    de_alu_op,
  output logic                    de_reg_write,
  output logic                    de_mem_read,
  output logic                    de_mem_write,
  output core_id_pkg::mem_op_e    de_mem_op,
  output core_id_pkg::br_op_e     de_br_op,
  output core_id_pkg::reg_addr_t  de_rd,
  output core_id_pkg::reg_addr_t  de_rs1,
  output core_id_pkg::reg_addr_t  de_rs2,
  output core_id_pkg::xlen_t      de_imm,
  output core_id_pkg::xlen_t      de_rs1_value,
  output core_id_pkg::xlen_t      de_rs2_value
);

  core_id_pkg::alu_op_e    alu_op;
  logic                    reg_write;
  logic                    mem_read;
  logic                    mem_write;
  core_id_pkg::mem_op_e    mem_op;
  core_id_pkg::br_op_e     br_op;
  core_id_pkg::reg_addr_t  rd;
  core_id_pkg::reg_addr_t  rs1;
  core_id_pkg::reg_addr_t  rs2;
  core_id_pkg::xlen_t      imm;
  core_id_pkg::xlen_t      rs1_value;
  core_id_pkg::xlen_t      rs2_value;

  id_ctrl_decode u_ctrl_decode (
    .instr     (fd_instr),
    .alu_op    (alu_op),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_op    (mem_op),
    .br_op     (br_op),
    .rd        (rd)
  );

  id_operand_read u_operand_read (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (fd_instr),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .imm          (imm),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .rs1          (rs1),
    .rs2          (rs2)
  );

  id_stage_reg u_stage_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .fd_valid     (fd_valid),
    .fd_ready     (fd_ready),
    .ex_flush_en  (ex_flush_en),
    .de_ready     (de_ready),
    .de_valid     (de_valid),
    .pc           (fd_pc),
    .alu_op       (alu_op),
    .reg_write    (reg_write),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_op       (mem_op),
    .br_op        (br_op),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .de_pc        (de_pc),
    .de_alu_op    (de_alu_op),
    .de_reg_write (de_reg_write),
    .de_mem_read  (de_mem_read),
    .de_mem_write (de_mem_write),
    .de_mem_op    (de_mem_op),
    .de_br_op     (de_br_op),
    .de_rd        (de_rd),
    .de_rs1       (de_rs1),
    .de_rs2       (de_rs2),
    .de_imm       (de_imm),
    .de_rs1_value (de_rs1_value),
    .de_rs2_value (de_rs2_value)
  );

endmodule

`default_nettype wire

// ==== core_id_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_id_sva (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ex_flush_en,
  input  logic                    de_valid,
  input  logic                    de_ready,
  input  core_id_pkg::xlen_t      de_pc,
  input  core_id_pkg::alu_op_e    de_alu_op,
  input  logic                    de_reg_write,
  input  logic                    de_mem_read,
  input  logic                    de_mem_write,
  input  core_id_pkg::mem_op_e    de_mem_op,
  input  core_id_pkg::br_op_e     de_br_op,
  input  core_id_pkg::reg_addr_t  de_rd,
  input  core_id_pkg::reg_addr_t  de_rs1,
  input  core_id_pkg::reg_addr_t  de_rs2,
  input  core_id_pkg::xlen_t      de_imm,
  input  core_id_pkg::xlen_t      de_rs1_value,
  input  core_id_pkg::xlen_t      de_rs2_value
);

  logic         stalled;
  logic [155:0] payload;   // Every de_ field side by side

  assign stalled = de_valid && !de_ready && !ex_flush_en;
  assign payload = {de_pc, de_alu_op, de_reg_write, de_mem_read, de_mem_write, de_mem_op,
                    de_br_op, de_rd, de_rs1, de_rs2, de_imm, de_rs1_value, de_rs2_value};

  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stalled |=> de_valid && $stable(payload))
    else $error("de_ outputs changed while execute held de_ready low");

  // A flush empties the stage no matter what de_ready did
  a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    ex_flush_en |=> !de_valid)
    else $error("de_valid still high after a flush cycle");

  a_reset_empty: assert property (@(posedge clk)
    $rose(rst_n) |-> !de_valid)
    else $error("de_valid high right after reset release");

endmodule

bind core_id core_id_sva u_sva (.*);

`default_nettype wire

// ==== tb_core_id_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module tb_core_id_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fd_valid,
  input  logic                    fd_ready,
  input  riscv_isa_pkg::instr_t   fd_instr,
  input  core_id_pkg::xlen_t      fd_pc,
  input  logic                    ex_flush_en,
  input  logic                    wb_reg_write,
  input  core_id_pkg::reg_addr_t  wb_rd,
  input  core_id_pkg::xlen_t      wb_data,
  input  logic                    de_valid,
  input  logic                    de_ready,
  input  core_id_pkg::xlen_t      de_pc,
  input  core_id_pkg::alu_op_e    de_alu_op,
  input  logic                    de_reg_write,
  input  logic                    de_mem_read,
  input  logic                    de_mem_write,
  input  core_id_pkg::mem_op_e    de_mem_op,
  input  core_id_pkg::br_op_e     de_br_op,
  input  core_id_pkg::reg_addr_t  de_rd,
  input  core_id_pkg::reg_addr_t  de_rs1,
  input  core_id_pkg::reg_addr_t  de_rs2,
  input  core_id_pkg::xlen_t      de_imm,
  input  core_id_pkg::xlen_t      de_rs1_value,
  input  core_id_pkg::xlen_t      de_rs2_value,
  output int                      error_count
);

  typedef struct packed {
    core_id_pkg::xlen_t      pc;
    logic [3:0]              alu_op;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic [2:0]              mem_op;
    logic [2:0]              br_op;
    core_id_pkg::reg_addr_t  rd;
    core_id_pkg::reg_addr_t  rs1;
    core_id_pkg::reg_addr_t  rs2;
    core_id_pkg::xlen_t      imm;
    core_id_pkg::xlen_t      rs1_value;
    core_id_pkg::xlen_t      rs2_value;
  } expect_t;

  core_id_pkg::xlen_t shadow [`REG_COUNT] = '{default: '0};   // Mirror of committed writes
  expect_t            expected_q [$];                         // Accepted, not yet handed on
  int                 errors = 0;

  assign error_count = errors;

  function automatic core_id_pkg::xlen_t read_value(core_id_pkg::reg_addr_t a);
    core_id_pkg::xlen_t v;
    if (a == 5'd0) begin
      v = '0;
    end else if (wb_reg_write && (wb_rd == a)) begin
      v = wb_data;   // Write landing in the same cycle is seen
    end else begin
      v = shadow[a];
    end
    return v;
  endfunction

  // --------------------
  // Reference decode
  // --------------------
  function automatic expect_t expected_decode(riscv_isa_pkg::instr_t i, core_id_pkg::xlen_t pc);
    expect_t            e;
    logic               writes;
    logic               alt;
    core_id_pkg::xlen_t imm_i;
    core_id_pkg::xlen_t imm_s;
    core_id_pkg::xlen_t imm_b;
    core_id_pkg::xlen_t imm_j;
    core_id_pkg::xlen_t imm_u;
    e      = '0;
    writes = 1'b0;
    alt    = (i[31:25] == 7'b0100000);
    imm_i  = {{20{i[31]}}, i[31:20]};
    imm_s  = {{20{i[31]}}, i[31:25], i[11:7]};
    imm_b  = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    imm_j  = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    imm_u  = {i[31:12], 12'b0};
    e.pc        = pc;
    e.rd        = i[11:7];
    e.rs1       = i[19:15];
    e.rs2       = i[24:20];
    e.rs1_value = read_value(i[19:15]);
    e.rs2_value = read_value(i[24:20]);
    case (i[6:2])
      5'b01100, 5'b00100: begin   // Bit 5 tells OP from OP_IMM
        writes = 1'b1;
        case (i[14:12])
          3'b000:  e.alu_op = (alt && i[5]) ? core_id_pkg::ALU_SUB : core_id_pkg::ALU_ADD;
          3'b001:  e.alu_op = core_id_pkg::ALU_SLL;
          3'b010:  e.alu_op = core_id_pkg::ALU_SLT;
          3'b011:  e.alu_op = core_id_pkg::ALU_SLTU;
          3'b100:  e.alu_op = core_id_pkg::ALU_XOR;
          3'b101:  e.alu_op = alt ? core_id_pkg::ALU_SRA : core_id_pkg::ALU_SRL;
          3'b110:  e.alu_op = core_id_pkg::ALU_OR;
          default: e.alu_op = core_id_pkg::ALU_AND;
        endcase
        if (!i[5]) begin
          e.imm = imm_i;
        end
      end
      5'b00000: begin
        writes     = 1'b1;
        e.mem_read = 1'b1;
        e.imm      = imm_i;
        case (i[14:12])
          3'b000:  e.mem_op = core_id_pkg::MEM_B;
          3'b001:  e.mem_op = core_id_pkg::MEM_H;
          3'b100:  e.mem_op = core_id_pkg::MEM_BU;
          3'b101:  e.mem_op = core_id_pkg::MEM_HU;
          default: e.mem_op = core_id_pkg::MEM_W;
        endcase
      end
      5'b01000: begin
        e.mem_write = 1'b1;
        e.imm       = imm_s;
        case (i[14:12])
          3'b000:  e.mem_op = core_id_pkg::MEM_B;
          3'b001:  e.mem_op = core_id_pkg::MEM_H;
          default: e.mem_op = core_id_pkg::MEM_W;
        endcase
      end
      5'b11000: begin
        e.imm = imm_b;
        case (i[14:12])
          3'b000:  e.br_op = core_id_pkg::BR_EQ;
          3'b001:  e.br_op = core_id_pkg::BR_NE;
          3'b100:  e.br_op = core_id_pkg::BR_LT;
          3'b101:  e.br_op = core_id_pkg::BR_GE;
          3'b110:  e.br_op = core_id_pkg::BR_LTU;
          3'b111:  e.br_op = core_id_pkg::BR_GEU;
          default: e.br_op = core_id_pkg::BR_NONE;
        endcase
      end
      5'b11011: begin
        writes  = 1'b1;
        e.br_op = core_id_pkg::BR_ALWAYS;
        e.imm   = imm_j;
      end
      5'b11001: begin
        writes  = 1'b1;
        e.br_op = core_id_pkg::BR_ALWAYS;
        e.imm   = imm_i;
      end
      5'b01101, 5'b00101: begin
        writes = 1'b1;
        e.imm  = imm_u;
      end
      default: e.imm = '0;   // Unknown class keeps every control low
    endcase
    e.reg_write = writes && (i[11:7] != 5'd0);
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_outputs(input expect_t e);
    check_field("de_pc", e.pc, de_pc);
    check_field("de_alu_op", 32'(e.alu_op), 32'(de_alu_op));
    check_field("de_reg_write", 32'(e.reg_write), 32'(de_reg_write));
    check_field("de_mem_read", 32'(e.mem_read), 32'(de_mem_read));
    check_field("de_mem_write", 32'(e.mem_write), 32'(de_mem_write));
    check_field("de_mem_op", 32'(e.mem_op), 32'(de_mem_op));
    check_field("de_br_op", 32'(e.br_op), 32'(de_br_op));
    check_field("de_rd", 32'(e.rd), 32'(de_rd));
    check_field("de_rs1", 32'(e.rs1), 32'(de_rs1));
    check_field("de_rs2", 32'(e.rs2), 32'(de_rs2));
    check_field("de_imm", e.imm, de_imm);
    check_field("de_rs1_value", e.rs1_value, de_rs1_value);
    check_field("de_rs2_value", e.rs2_value, de_rs2_value);
  endtask

  // --------------------
  // Mid-cycle sampling, all inputs settled
  // --------------------
  always @(negedge clk) begin
    expect_t head;
    if (rst_n) begin
      check_field("fd_ready",
                  32'(!ex_flush_en && ((expected_q.size() == 0) || de_ready)),
                  32'(fd_ready));
      check_field("de_valid", 32'(expected_q.size() != 0), 32'(de_valid));
      if (ex_flush_en) begin
        expected_q.delete();   // Held instruction is cancelled at the edge
      end else begin
        if (de_valid && de_ready) begin
          if (expected_q.size() == 0) begin
            $display("Output transfer seen with no accepted instruction pending");
            errors++;
          end else begin
            head = expected_q.pop_front();
            compare_outputs(head);
          end
        end
        if (fd_valid && fd_ready) begin
          expected_q.push_back(expected_decode(fd_instr, fd_pc));
        end
      end
      if (wb_reg_write && (wb_rd != 5'd0)) begin
        shadow[wb_rd] = wb_data;   // Commits at the coming edge
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_core_id.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core_id;

  localparam int NUM_INSTR  = 600;
  localparam int WAIT_LIMIT = 100;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    fd_valid;
  logic                    fd_ready;
  riscv_isa_pkg::instr_t   fd_instr;
  core_id_pkg::xlen_t      fd_pc;
  logic                    ex_flush_en;
  logic                    wb_reg_write;
  core_id_pkg::reg_addr_t  wb_rd;
  core_id_pkg::xlen_t      wb_data;
  logic                    de_valid;
  logic                    de_ready;
  core_id_pkg::xlen_t      de_pc;
  core_id_pkg::alu_op_e    de_alu_op;
  logic                    de_reg_write;
  logic                    de_mem_read;
  logic                    de_mem_write;
  core_id_pkg::mem_op_e    de_mem_op;
  core_id_pkg::br_op_e     de_br_op;
  core_id_pkg::reg_addr_t  de_rd;
  core_id_pkg::reg_addr_t  de_rs1;
  core_id_pkg::reg_addr_t  de_rs2;
  core_id_pkg::xlen_t      de_imm;
  core_id_pkg::xlen_t      de_rs1_value;
  core_id_pkg::xlen_t      de_rs2_value;

  int          error_count;
  int          timeouts = 0;
  logic [31:0] lfsr_state = 32'h4326_a6e4;

  always #4 clk = ~clk;

  core_id DUT (.*);

  tb_core_id_checker u_checker (.*);

  // --------------------
  // Random source
  // --------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};   // One step per bit
    end
    return v;
  endfunction

  function automatic riscv_isa_pkg::instr_t make_instr();
    logic [31:0] w;
    logic [3:0]  cls;
    w      = rand_bits(32);   // Random fields, fixed up per class below
    cls    = 4'(rand_bits(4));
    w[1:0] = 2'b11;
    case (cls)
      4'd0, 4'd1, 4'd13: begin
        w[6:2]   = 5'b01100;
        w[31:25] = w[30] ? 7'b0100000 : 7'b0000000;
      end
      4'd2, 4'd3, 4'd14: begin
        w[6:2] = 5'b00100;
        if (w[13:12] == 2'b01) begin
          w[31:25] = (w[14] && w[30]) ? 7'b0100000 : 7'b0000000;   // Legal shift funct7
        end
      end
      4'd4: begin
        w[6:2] = 5'b00000;
        if (w[13:12] == 2'b11 || w[14:13] == 2'b11) begin
          w[14:12] = 3'b010;
        end
      end
      4'd5: begin
        w[6:2] = 5'b01000;
        w[14]  = 1'b0;
        if (w[13:12] == 2'b11) begin
          w[14:12] = 3'b010;
        end
      end
      4'd6, 4'd7: begin
        w[6:2] = 5'b11000;
        if (w[14:13] == 2'b01) begin
          w[13] = 1'b0;
        end
      end
      4'd8:  w[6:2] = 5'b11011;
      4'd9: begin
        w[6:2]   = 5'b11001;
        w[14:12] = 3'b000;
      end
      4'd10: w[6:2] = 5'b01101;
      4'd11: w[6:2] = 5'b00101;
      default: w[6:2] = w[20] ? 5'b11100 : 5'b00011;   // SYSTEM or FENCE, not decoded
    endcase
    return w;
  endfunction

  // --------------------
  // Cycle drivers
  // --------------------
  task automatic step_cycle(output logic accepted);
    de_ready     = (rand_bits(2) != 32'd0);
    ex_flush_en  = (rand_bits(4) == 32'd0);
    wb_reg_write = (rand_bits(1) != 32'd0);
    wb_rd        = core_id_pkg::reg_addr_t'(rand_bits(5));
    wb_data      = rand_bits(32);
    @(negedge clk);
    accepted = fd_valid && fd_ready;
    @(posedge clk);
    #1;
  endtask

  task automatic send_instr(input riscv_isa_pkg::instr_t instr, input core_id_pkg::xlen_t pc);
    int   waited;
    logic accepted;
    fd_valid = 1'b1;
    fd_instr = instr;
    fd_pc    = pc;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < WAIT_LIMIT) begin
      step_cycle(accepted);
      waited++;
    end
    fd_valid = 1'b0;
    if (!accepted) begin
      $display("Timeout while waiting for fd_ready, pc %h never accepted", pc);
      timeouts++;
    end
  endtask

  task automatic drain_output();
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy && waited < WAIT_LIMIT) begin
      de_ready     = 1'b1;
      ex_flush_en  = 1'b0;
      wb_reg_write = 1'b0;
      @(negedge clk);
      busy = de_valid;
      @(posedge clk);
      #1;
      waited++;
    end
    if (busy) begin
      $display("Timeout while draining, de_valid stayed high");
      timeouts++;
    end
  endtask

  initial begin
    core_id_pkg::xlen_t pc;
    logic               unused;
    rst_n        = 1'b0;
    fd_valid     = 1'b0;
    fd_instr     = '0;
    fd_pc        = '0;
    ex_flush_en  = 1'b0;
    wb_reg_write = 1'b0;
    wb_rd        = '0;
    wb_data      = '0;
    de_ready     = 1'b0;
    pc           = 32'h0000_1000;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int n = 0; n < NUM_INSTR && timeouts == 0; n++) begin
      if (rand_bits(2) == 32'd0) begin
        step_cycle(unused);   // Bubble from fetch
      end
      send_instr(make_instr(), pc);
      pc = pc + 32'd4;
    end
    drain_output();
    $display("Closing count: %0d check errors, %0d timeouts", error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
riscv_isa_pkg.sv
core_id_pkg.sv
id_ctrl_decode.sv
id_operand_read.sv
id_stage_reg.sv
core_id.sv
core_id_sva.sv
tb_core_id_checker.sv
tb_core_id.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_core_id -f list.f \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_core_id > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Something failed" "$log"; then
  exit 1
fi
exit 0
